/* compile.f */
hw/atc_pkg.sv
hw/message_fifo.sv
hw/id_allocator.sv
hw/runway_lock.sv
hw/flight_request_sequencer.sv
hw/reply_encoder.sv
hw/tower_controller.sv
testbench/tower_tb.sv

/* hw/atc_pkg.sv */
package atc_pkg;

	// ##############################
	// Sizing

	localparam int message_width = 8;
	localparam int plane_id_width = 4;
	localparam int plane_count = 16;
	localparam int runway_count = 2;
	localparam int request_queue_depth = 4;
	localparam int plane_queue_depth = 8;
	localparam int reply_queue_depth = 4;

	// ##############################
	// Message format

	typedef logic [plane_id_width-1:0] plane_id_t;

	typedef struct packed {
		plane_id_t plane;
		logic [2:0] kind; // Request type on the way in, reply type on the way out.
		logic flag;
	} message_t;

	typedef enum logic [2:0] {
		msg_request = 3'b000,
		msg_done = 3'b001,
		msg_id_request = 3'b111
	} msg_type_e;

	typedef enum logic [2:0] {
		reply_clear = 3'b011,
		reply_hold = 3'b100,
		reply_say_again = 3'b101,
		reply_divert = 3'b110,
		reply_id = 3'b111
	} reply_kind_e;

	localparam logic action_takeoff = 1'b0;
	localparam logic action_landing = 1'b1;

	typedef enum logic [2:0] {
		seq_idle,
		seq_decode,
		seq_reply,
		seq_schedule,
		seq_clear_takeoff,
		seq_clear_landing,
		seq_send_clear
	} seq_state_e;

endpackage

/* hw/flight_request_sequencer.sv */
module flight_request_sequencer (
	input logic clock,
	input logic reset,
	input atc_pkg::message_t request,
	input logic request_empty,
	output logic request_read,
	input logic takeoff_empty,
	input logic takeoff_full,
	input atc_pkg::plane_id_t takeoff_head,
	output logic takeoff_push,
	output logic takeoff_pop,
	input logic landing_empty,
	input logic landing_full,
	input atc_pkg::plane_id_t landing_head,
	output logic landing_push,
	output logic landing_pop,
	input logic query_taken,
	input logic exhausted,
	input atc_pkg::plane_id_t free_id,
	output logic take,
	output logic release_plane,
	output atc_pkg::plane_id_t release_id,
	input logic [atc_pkg::runway_count-1:0] runway_active,
	output logic lock,
	output logic unlock,
	output atc_pkg::plane_id_t lock_id,
	output logic [$clog2(atc_pkg::runway_count)-1:0] runway_select,
	input logic reply_full,
	output logic reply_load,
	output atc_pkg::reply_kind_e reply_kind,
	output atc_pkg::plane_id_t reply_plane,
	output logic reply_flag,
	output logic reply_push
);
	import atc_pkg::*;

	seq_state_e state;
	seq_state_e next_state;
	logic takeoff_first;
	logic toggle_fairness;
	logic can_schedule;
	logic pick_takeoff;
	logic queue_full;
	logic [$clog2(runway_count)-1:0] free_runway;

	assign can_schedule = !(&runway_active) && !(takeoff_empty && landing_empty);
	assign pick_takeoff = !takeoff_empty && (landing_empty || takeoff_first);
	assign queue_full = (request.flag == action_takeoff) ? takeoff_full : landing_full;
	assign release_id = request.plane;
	assign lock_id = (state == seq_clear_takeoff) ? takeoff_head : landing_head;

	always_comb begin
		free_runway = '0;
		for (int i = runway_count - 1; i >= 0; i--) begin
			if (!runway_active[i])
				free_runway = i[$bits(free_runway)-1:0];
		end
	end

	// ##############################
	// Decode and schedule

	always_comb begin
		next_state = state;
		request_read = 1'b0;
		takeoff_push = 1'b0;
		takeoff_pop = 1'b0;
		landing_push = 1'b0;
		landing_pop = 1'b0;
		take = 1'b0;
		release_plane = 1'b0;
		lock = 1'b0;
		unlock = 1'b0;
		runway_select = free_runway;
		reply_load = 1'b0;
		reply_kind = reply_hold;
		reply_plane = request.plane;
		reply_flag = 1'b0;
		reply_push = 1'b0;
		toggle_fairness = 1'b0;
		case (state)
			seq_idle: begin
				if (!request_empty)
					next_state = seq_decode;
				else if (can_schedule)
					next_state = seq_schedule;
			end
			seq_decode: begin
				request_read = 1'b1;
				next_state = seq_schedule; // Unless a reply is owed.
				case (request.kind)
					msg_id_request: begin
						reply_load = 1'b1;
						reply_kind = reply_id;
						next_state = seq_reply;
						if (exhausted) begin
							reply_plane = '0;
							reply_flag = 1'b1;
						end else begin
							take = 1'b1;
							reply_plane = free_id;
						end
					end
					msg_request: begin
						if (query_taken) begin
							reply_load = 1'b1;
							next_state = seq_reply;
							if (queue_full) begin
								reply_kind = reply_divert;
								release_plane = 1'b1;
							end else begin
								takeoff_push = request.flag == action_takeoff;
								landing_push = request.flag == action_landing;
							end
						end
					end
					msg_done: begin
						if (query_taken) begin
							unlock = 1'b1;
							release_plane = 1'b1;
							runway_select = request.flag;
						end
					end
					default: begin
						reply_load = 1'b1;
						reply_kind = reply_say_again;
						next_state = seq_reply;
					end
				endcase
			end
			seq_reply: begin
				if (!reply_full) begin
					reply_push = 1'b1;
					next_state = seq_schedule;
				end
			end
			seq_schedule: begin
				if (can_schedule) begin
					next_state = pick_takeoff ? seq_clear_takeoff : seq_clear_landing;
					toggle_fairness = !takeoff_empty && !landing_empty;
				end else begin
					next_state = seq_idle;
				end
			end
			seq_clear_takeoff, seq_clear_landing: begin
				lock = 1'b1;
				takeoff_pop = state == seq_clear_takeoff;
				landing_pop = state == seq_clear_landing;
				reply_load = 1'b1;
				reply_kind = reply_clear;
				reply_plane = lock_id;
				reply_flag = free_runway[0]; // Runway number rides in the flag.
				next_state = seq_send_clear;
			end
			seq_send_clear: begin
				if (!reply_full) begin
					reply_push = 1'b1;
					next_state = seq_idle;
				end
			end
			default: next_state = seq_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= seq_idle;
			takeoff_first <= 1'b1;
		end else begin
			state <= next_state;
			if (toggle_fairness)
				takeoff_first <= !takeoff_first;
		end
	end

	lock_unlock_exclusive: assert property (@(posedge clock) disable iff (reset) !(lock && unlock))
		else $error("lock and unlock in the same cycle");

endmodule

/* hw/id_allocator.sv */
module id_allocator (
	input logic clock,
	input logic reset,
	input logic take,
	input logic release_plane,
	input atc_pkg::plane_id_t release_id,
	input atc_pkg::plane_id_t query_id,
	output atc_pkg::plane_id_t free_id,
	output logic query_taken,
	output logic exhausted
);
	import atc_pkg::*;

	logic [plane_count-1:0] taken;

	// Walk down so the lowest free ID is the one left standing.
	always_comb begin
		free_id = '0;
		for (int i = plane_count - 1; i >= 0; i--) begin
			if (!taken[i])
				free_id = i[plane_id_width-1:0];
		end
	end

	assign query_taken = taken[query_id];
	assign exhausted = &taken;

	always_ff @(posedge clock) begin
		if (reset)
			taken <= '0;
		else if (release_plane)
			taken[release_id] <= 1'b0; // Release has priority over take.
		else if (take && !exhausted)
			taken[free_id] <= 1'b1;
	end

endmodule

/* hw/message_fifo.sv */
module message_fifo #(
	parameter int width = 8,
	parameter int depth = 4
) (
	input logic clock,
	input logic reset,
	input logic [width-1:0] write_data,
	input logic write,
	input logic read,
	output logic [width-1:0] read_data,
	output logic full,
	output logic empty
);
	localparam int pointer_width = $clog2(depth);

	logic [width-1:0] memory [depth];
	logic [pointer_width-1:0] write_pointer;
	logic [pointer_width-1:0] read_pointer;
	logic [pointer_width:0] count;
	logic do_write;
	logic do_read;

	function automatic logic [pointer_width-1:0] advance(input logic [pointer_width-1:0] pointer);
		if (int'(pointer) == depth - 1)
			return '0;
		return pointer + 1'b1;
	endfunction

	assign full = int'(count) == depth;
	assign empty = count == '0;
	assign do_write = write && !full;
	assign do_read = read && !empty;
	assign read_data = memory[read_pointer]; // Head is visible without a read.

	always_ff @(posedge clock) begin
		if (do_write)
			memory[write_pointer] <= write_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			count <= '0;
		end else begin
			if (do_write)
				write_pointer <= advance(write_pointer);
			if (do_read)
				read_pointer <= advance(read_pointer);
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	no_overflow: assert property (@(posedge clock) disable iff (reset) !(write && full))
		else $error("message_fifo written while full");
	no_underflow: assert property (@(posedge clock) disable iff (reset) !(read && empty))
		else $error("message_fifo read while empty");

endmodule

/* hw/reply_encoder.sv */
module reply_encoder (
	input logic clock,
	input logic reset,
	input logic reply_load,
	input atc_pkg::reply_kind_e reply_kind,
	input atc_pkg::plane_id_t reply_plane,
	input logic reply_flag,
	input logic reply_push,
	input logic reply_ready,
	output logic reply_full,
	output atc_pkg::message_t reply_data,
	output logic reply_valid
);
	import atc_pkg::*;

	message_t reply_byte;
	logic reply_empty;

	// Byte is held here until the sequencer can push it.
	always_ff @(posedge clock) begin
		if (reply_load) begin
			reply_byte.plane <= reply_plane;
			reply_byte.kind <= reply_kind;
			reply_byte.flag <= reply_flag;
		end
	end

	assign reply_valid = !reply_empty;

	message_fifo #(
		.width(message_width),
		.depth(reply_queue_depth)
	) reply_queue (
		.clock(clock),
		.reset(reset),
		.write_data(reply_byte),
		.write(reply_push),
		.read(reply_ready && reply_valid),
		.read_data(reply_data),
		.full(reply_full),
		.empty(reply_empty)
	);

endmodule

/* hw/runway_lock.sv */
module runway_lock (
	input logic clock,
	input logic reset,
	input logic lock,
	input logic unlock,
	input atc_pkg::plane_id_t lock_id,
	input atc_pkg::plane_id_t unlock_id,
	input logic [$clog2(atc_pkg::runway_count)-1:0] runway_select,
	output logic [atc_pkg::runway_count-1:0] runway_active
);
	import atc_pkg::*;

	plane_id_t owner [runway_count];
	logic [runway_count-1:0] busy;

	assign runway_active = busy;

	always_ff @(posedge clock) begin
		if (lock)
			owner[runway_select] <= lock_id;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else if (lock) begin
			busy[runway_select] <= 1'b1;
		end else if (unlock && unlock_id == owner[runway_select]) begin
			busy[runway_select] <= 1'b0; // Only the owner may free a runway.
		end
	end

	// The sequencer must only clear a plane onto a runway it saw as free.
	lock_free_runway: assert property (@(posedge clock) disable iff (reset)
		lock |-> !busy[runway_select])
		else $error("runway locked while busy");

endmodule

/* hw/tower_controller.sv */
module tower_controller (
	input logic clock,
	input logic reset,
	input atc_pkg::message_t request_data,
	input logic request_valid,
	output logic request_ready,
	output atc_pkg::message_t reply_data,
	output logic reply_valid,
	input logic reply_ready,
	output logic [atc_pkg::runway_count-1:0] runway_active
);
	import atc_pkg::*;

	message_t request_head;
	logic request_full, request_empty, request_read;
	logic takeoff_full, takeoff_empty, takeoff_push, takeoff_pop;
	logic landing_full, landing_empty, landing_push, landing_pop;
	plane_id_t takeoff_head, landing_head;
	logic take, release_plane, query_taken, exhausted;
	plane_id_t release_id, free_id, lock_id;
	logic lock, unlock;
	logic [$clog2(runway_count)-1:0] runway_select;
	logic reply_full, reply_load, reply_flag, reply_push;
	reply_kind_e reply_kind;
	plane_id_t reply_plane;

	assign request_ready = !request_full;

	// ##############################
	// Queues

	message_fifo #(.width(message_width), .depth(request_queue_depth)) request_queue (
		.clock(clock), .reset(reset),
		.write_data(request_data), .write(request_valid && request_ready), .read(request_read),
		.read_data(request_head), .full(request_full), .empty(request_empty)
	);

	message_fifo #(.width(plane_id_width), .depth(plane_queue_depth)) takeoff_queue (
		.clock(clock), .reset(reset),
		.write_data(request_head.plane), .write(takeoff_push), .read(takeoff_pop),
		.read_data(takeoff_head), .full(takeoff_full), .empty(takeoff_empty)
	);

	message_fifo #(.width(plane_id_width), .depth(plane_queue_depth)) landing_queue (
		.clock(clock), .reset(reset),
		.write_data(request_head.plane), .write(landing_push), .read(landing_pop),
		.read_data(landing_head), .full(landing_full), .empty(landing_empty)
	);

	// ##############################
	// Control and bookkeeping

	flight_request_sequencer sequencer (.*, .request(request_head));

	id_allocator allocator (.*, .query_id(request_head.plane));

	runway_lock runways (.*, .unlock_id(request_head.plane));

	reply_encoder encoder (.*);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the tower controller testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module tower_tb -o tower_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tower_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit "$status"
fi

exit 0

/* testbench/tower_tb.sv */
module tower_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [2:0] type_request = 3'b000;
	localparam logic [2:0] type_done = 3'b001;
	localparam logic [2:0] type_unknown = 3'b011;
	localparam logic [2:0] type_id_request = 3'b111;
	localparam logic [2:0] kind_clear = 3'b011;
	localparam logic [2:0] kind_hold = 3'b100;
	localparam logic [2:0] kind_say_again = 3'b101;
	localparam logic [2:0] kind_divert = 3'b110;
	localparam logic [2:0] kind_id = 3'b111;
	localparam int cycle_limit = 4000; // About forty requests at well under a hundred cycles each.

	logic clock;
	logic reset;
	logic [7:0] request_data;
	logic request_valid;
	logic request_ready;
	logic [7:0] reply_data;
	logic reply_valid;
	logic reply_ready;
	logic [1:0] runway_active;
	logic [31:0] lcg_state = 32'd60;
	int cycle_count = 0;

	tower_controller uut (
		.clock(clock),
		.reset(reset),
		.request_data(request_data),
		.request_valid(request_valid),
		.request_ready(request_ready),
		.reply_data(reply_data),
		.reply_valid(reply_valid),
		.reply_ready(reply_ready),
		.runway_active(runway_active)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ##############################
	// Helpers

	function automatic logic [7:0] make_message(input logic [3:0] plane, input logic [2:0] kind,
			input logic flag);
		return {plane, kind, flag};
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected)
			stop_run($sformatf("mismatch at %0.1f ns: %s expected 0x%02h, got 0x%02h",
				$realtime, name, expected, actual));
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic idle_gap();
		logic [31:0] value;
		value = lcg_next();
		repeat (int'(value[17:16])) next_cycle(); // Upper bits of the LCG are the better ones.
	endtask

	task automatic send_request(input logic [7:0] message);
		request_data = message;
		request_valid = 1'b1;
		while (!request_ready)
			next_cycle();
		next_cycle(); // Byte is taken at this edge.
		request_valid = 1'b0;
		idle_gap();
	endtask

	task automatic expect_reply(input logic [7:0] expected);
		while (!reply_valid)
			next_cycle();
		compare_value("reply_data", reply_data, expected);
		reply_ready = 1'b1;
		next_cycle();
		reply_ready = 1'b0;
	endtask

	task automatic expect_silence(input int cycles);
		repeat (cycles) begin
			compare_value("reply_valid", 8'(reply_valid), 8'h00);
			next_cycle();
		end
	endtask

	// ##############################
	// Directed tests

	task automatic test_reset();
		compare_value("request_ready", 8'(request_ready), 8'h01);
		compare_value("reply_valid", 8'(reply_valid), 8'h00);
		compare_value("runway_active", 8'(runway_active), 8'h00);
	endtask

	task automatic test_id_handout();
		for (int id = 0; id < 3; id++) begin
			send_request(make_message(4'h0, type_id_request, 1'b0));
			expect_reply(make_message(4'(id), kind_id, 1'b0));
		end
	endtask

	// Nine requests fill the reply queue, park one in the sequencer and fill the request queue.
	task automatic test_back_pressure();
		int waited;
		waited = 0;
		for (int n = 0; n < 9; n++)
			send_request(make_message(4'h0, type_id_request, 1'b0));
		while (request_ready && waited < 20) begin
			next_cycle();
			waited++;
		end
		compare_value("request_ready", 8'(request_ready), 8'h00);
		for (int id = 3; id < 12; id++)
			expect_reply(make_message(4'(id), kind_id, 1'b0));
	endtask

	task automatic test_id_exhaustion();
		for (int id = 12; id < 16; id++) begin
			send_request(make_message(4'h0, type_id_request, 1'b0));
			expect_reply(make_message(4'(id), kind_id, 1'b0));
		end
		send_request(make_message(4'h0, type_id_request, 1'b0));
		expect_reply(make_message(4'h0, kind_id, 1'b1));
	endtask

	task automatic test_runways();
		send_request(make_message(4'h0, type_request, 1'b0));
		expect_reply(make_message(4'h0, kind_hold, 1'b0));
		expect_reply(make_message(4'h0, kind_clear, 1'b0));
		send_request(make_message(4'h1, type_request, 1'b1));
		expect_reply(make_message(4'h1, kind_hold, 1'b0));
		expect_reply(make_message(4'h1, kind_clear, 1'b1)); // Runway 0 is taken by plane 0.
		send_request(make_message(4'h2, type_request, 1'b0));
		expect_reply(make_message(4'h2, kind_hold, 1'b0));
		expect_silence(12);
		compare_value("runway_active", 8'(runway_active), 8'h03);
		send_request(make_message(4'h0, type_done, 1'b0));
		expect_reply(make_message(4'h2, kind_clear, 1'b0));
		compare_value("runway_active", 8'(runway_active), 8'h03);
	endtask

	task automatic test_divert_say_again();
		for (int plane = 3; plane < 11; plane++) begin
			send_request(make_message(4'(plane), type_request, 1'b0));
			expect_reply(make_message(4'(plane), kind_hold, 1'b0));
		end
		send_request(make_message(4'hb, type_request, 1'b0));
		expect_reply(make_message(4'hb, kind_divert, 1'b0));
		send_request(make_message(4'hc, type_unknown, 1'b0));
		expect_reply(make_message(4'hc, kind_say_again, 1'b0));
		send_request(make_message(4'hb, type_request, 1'b0)); // ID 11 was released by the divert.
		send_request(make_message(4'h0, type_done, 1'b1));
		send_request(make_message(4'hd, type_unknown, 1'b0));
		expect_reply(make_message(4'hd, kind_say_again, 1'b0));
	endtask

	// ##############################
	// Run control

	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		stop_run("timeout: the tests did not finish within the cycle limit");
	end

	initial begin
		reset = 1'b1;
		request_data = 8'h00;
		request_valid = 1'b0;
		reply_ready = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset();
		test_id_handout();
		test_back_pressure();
		test_id_exhaustion();
		test_runways();
		test_divert_say_again();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
